//--- list.f
rtl/spi_pkg.sv
rtl/byte_fifo.sv
rtl/sck_phase_gen.sv
rtl/spi_sequencer.sv
rtl/spi_shifter.sv
rtl/spi_master_top.sv
testbench/spi_master_assertions.sv
testbench/tb_spi_master.sv

//--- rtl/byte_fifo.sv
/* synchronous byte FIFO with a registered read port and one-cycle valid.
   used for both the TX and the RX queue of the SPI master */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import spi_pkg::*; (
  input  wire   i_ext_spi_clk_x,
  input  wire   i_srst,
  input  wire   wr_en_i,
  input  byte_t wr_data_i,
  input  wire   rd_en_i,
  output byte_t rd_data_o,
  output logic  rd_valid_o,
  output logic  full_o,
  output logic  empty_o
);

  byte_t mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  // one extra bit so a full buffer is distinguishable from empty
  logic [FIFO_AW:0] count_q;
  logic do_wr;
  logic do_rd;

  assign full_o  = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // requests against a full or empty buffer are dropped here
  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= do_rd;
      if (do_wr)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_rd)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // read and write together leave occupancy as is
      if (do_wr && !do_rd)
        count_q <= count_q + 1'b1;
      else if (do_rd && !do_wr)
        count_q <= count_q - 1'b1;
    end
  end

  // storage and read register
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_wr)
      mem[wr_ptr_q] <= wr_data_i;
    if (do_rd)
      rd_data_o <= mem[rd_ptr_q];
  end

endmodule

`default_nettype wire

//--- rtl/sck_phase_gen.sv
/* free running SCK phase counter with fall and rise strobes */
`timescale 1ns/1ns
`default_nettype none

module sck_phase_gen import spi_pkg::*; (
  input  wire  i_ext_spi_clk_x,
  input  wire  i_srst,
  output logic fall_stb_o,
  output logic rise_stb_o,
  output logic sck_high_o
);

  logic [SCK_PW-1:0] phase_q;

  // wraps every SCK_RATIO clocks
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      phase_q <= '0;
    else if (phase_q == SCK_PW'(SCK_RATIO - 1))
      phase_q <= '0;
    else
      phase_q <= phase_q + 1'b1;
  end

  // falling edge point opens the period, rising edge point at the half
  assign fall_stb_o = (phase_q == '0);
  assign rise_stb_o = (phase_q == SCK_PW'(SCK_RATIO / 2));
  // second half of the period is SCK high
  assign sck_high_o = (phase_q >= SCK_PW'(SCK_RATIO / 2));

endmodule

`default_nettype wire

//--- rtl/spi_master_top.sv
/* SPI Mode 0 master top level with TX and RX byte FIFOs.
   host loads TX bytes, pulses go_i while idle, then drains RX bytes */
`timescale 1ns/1ns
`default_nettype none

module spi_master_top import spi_pkg::*; (
  input  wire   i_ext_spi_clk_x,
  input  wire   i_srst,
  // host TX queue
  input  byte_t tx_data_i,
  input  wire   tx_enqueue_i,
  output logic  tx_ready_o,
  // host RX queue
  input  wire   rx_dequeue_i,
  output byte_t rx_data_o,
  output logic  rx_valid_o,
  output logic  rx_avail_o,
  // transaction control
  input  wire   go_i,
  input  len_t  tx_len_i,
  input  len_t  rx_len_i,
  input  wait_t wait_cyc_i,
  output logic  idle_o,
  // SPI bus
  output logic  sck_o,
  output logic  csn_o,
  output logic  copi_o,
  input  wire   cipo_i
);

  logic  fall_stb;
  logic  rise_stb;
  logic  sck_high;
  logic  tx_pop;
  logic  tx_shift;
  logic  rx_sample;
  logic  rx_last_bit;
  byte_t tx_byte;
  logic  tx_byte_valid;
  logic  tx_full;
  byte_t rx_byte;
  logic  rx_wr;
  logic  rx_empty;

  assign tx_ready_o = !tx_full;
  assign rx_avail_o = !rx_empty;

  sck_phase_gen u_phase (
    .i_ext_spi_clk_x, .i_srst,
    .fall_stb_o(fall_stb), .rise_stb_o(rise_stb), .sck_high_o(sck_high)
  );

  spi_sequencer u_seq (
    .i_ext_spi_clk_x, .i_srst,
    .go_i, .tx_len_i, .rx_len_i, .wait_cyc_i,
    .fall_stb_i(fall_stb), .rise_stb_i(rise_stb), .sck_high_i(sck_high),
    .idle_o, .csn_o, .sck_o,
    .tx_pop_o(tx_pop), .tx_shift_o(tx_shift),
    .rx_sample_o(rx_sample), .rx_last_bit_o(rx_last_bit)
  );

  spi_shifter u_shift (
    .i_ext_spi_clk_x, .i_srst,
    .fall_stb_i(fall_stb), .rise_stb_i(rise_stb),
    .tx_shift_i(tx_shift), .tx_byte_i(tx_byte), .tx_byte_valid_i(tx_byte_valid),
    .rx_sample_i(rx_sample), .rx_last_bit_i(rx_last_bit),
    .cipo_i, .copi_o, .rx_byte_o(rx_byte), .rx_wr_o(rx_wr)
  );

  // host writes, sequencer reads
  byte_fifo u_tx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .wr_en_i(tx_enqueue_i), .wr_data_i(tx_data_i), .rd_en_i(tx_pop),
    .rd_data_o(tx_byte), .rd_valid_o(tx_byte_valid),
    .full_o(tx_full), .empty_o()
  );

  // shifter writes, host reads
  byte_fifo u_rx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .wr_en_i(rx_wr), .wr_data_i(rx_byte), .rd_en_i(rx_dequeue_i),
    .rd_data_o(rx_data_o), .rd_valid_o(rx_valid_o),
    .full_o(), .empty_o(rx_empty)
  );

endmodule

`default_nettype wire

//--- rtl/spi_pkg.sv
/* shared constants, widths and FSM state encoding for the SPI master.
   imported by every RTL module and by the bound assertion module */
`default_nettype none

package spi_pkg;

  // system clocks per SCK period, falling strobe on phase 0
  localparam int SCK_RATIO = 8;
  // phase counter width
  localparam int SCK_PW = $clog2(SCK_RATIO);
  // SCK periods in each chip select lead-in and tail state
  localparam int SS_PERIODS = 4;

  // byte FIFO geometry
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

  typedef logic [7:0] byte_t;
  // byte count, 15 max
  typedef logic [3:0] len_t;
  // wait SCK periods between TX and RX
  typedef logic [1:0] wait_t;
  // SCK periods spent in one state, 8 x 15 at most
  typedef logic [6:0] timer_t;

  // transaction order, csn low from START_S through STOP_S
  typedef enum logic [2:0] {
    ST_IDLE, ST_START_D, ST_START_S, ST_TX,
    ST_WAIT, ST_RX, ST_STOP_S, ST_STOP_D
  } spi_state_e;

endpackage

`default_nettype wire

//--- rtl/spi_sequencer.sv
/* transaction FSM for the SPI master, steps once per SCK falling point.
   decodes chip select, SCK gating, TX pop points and RX sample points */
`timescale 1ns/1ns
`default_nettype none

module spi_sequencer import spi_pkg::*; (
  input  wire   i_ext_spi_clk_x,
  input  wire   i_srst,
  input  wire   go_i,
  input  len_t  tx_len_i,
  input  len_t  rx_len_i,
  input  wait_t wait_cyc_i,
  input  wire   fall_stb_i,
  input  wire   rise_stb_i,
  input  wire   sck_high_i,
  output logic  idle_o,
  output logic  csn_o,
  output logic  sck_o,
  output logic  tx_pop_o,
  output logic  tx_shift_o,
  output logic  rx_sample_o,
  output logic  rx_last_bit_o
);

  spi_state_e state_q;
  spi_state_e state_nx;
  timer_t     timer_q;
  timer_t     dur;
  logic       last;
  logic       go_pend_q;
  len_t       tx_len_q;
  len_t       rx_len_q;
  wait_t      wait_q;

  ////////////////////////////////////////////////////////////
  // state length and next state
  ////////////////////////////////////////////////////////////

  // SCK periods spent in the current state
  always_comb begin
    case (state_q)
      ST_TX:   dur = {tx_len_q, 3'b000};
      ST_WAIT: dur = timer_t'(wait_q);
      ST_RX:   dur = {rx_len_q, 3'b000};
      ST_IDLE: dur = '0;
      default: dur = timer_t'(SS_PERIODS);
    endcase
  end

  // final SCK period of this state
  assign last = (timer_q == dur - timer_t'(1));

  always_comb begin
    state_nx = state_q;
    case (state_q)
      ST_IDLE:    if (go_pend_q) state_nx = ST_START_D;
      ST_START_D: if (last) state_nx = ST_START_S;
      ST_START_S: if (last) state_nx = ST_TX;
      ST_TX: begin
        // wait only makes sense ahead of a receive phase
        if (last) begin
          if (rx_len_q == '0)
            state_nx = ST_STOP_S;
          else if (wait_q == '0)
            state_nx = ST_RX;
          else
            state_nx = ST_WAIT;
        end
      end
      ST_WAIT:    if (last) state_nx = ST_RX;
      ST_RX:      if (last) state_nx = ST_STOP_S;
      ST_STOP_S:  if (last) state_nx = ST_STOP_D;
      ST_STOP_D:  if (last) state_nx = ST_IDLE;
      default:    state_nx = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q   <= ST_IDLE;
      timer_q   <= '0;
      go_pend_q <= 1'b0;
      tx_len_q  <= '0;
      rx_len_q  <= '0;
      wait_q    <= '0;
    end else begin
      // start request held until the next falling point
      if (idle_o && go_i) begin
        go_pend_q <= 1'b1;
        tx_len_q  <= tx_len_i;
        rx_len_q  <= rx_len_i;
        wait_q    <= wait_cyc_i;
      end else if (fall_stb_i && state_q == ST_IDLE) begin
        go_pend_q <= 1'b0;
      end
      if (fall_stb_i) begin
        state_q <= state_nx;
        // timer restarts on each state change
        if (state_nx != state_q || state_q == ST_IDLE)
          timer_q <= '0;
        else
          timer_q <= timer_q + timer_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output decode
  ////////////////////////////////////////////////////////////

  assign idle_o = (state_q == ST_IDLE) && !go_pend_q;
  assign csn_o  = (state_q == ST_IDLE) || (state_q == ST_START_D) ||
                  (state_q == ST_STOP_D);
  // SCK runs only through TX, WAIT and RX
  assign sck_o  = sck_high_i &&
                  ((state_q == ST_TX) || (state_q == ST_WAIT) || (state_q == ST_RX));

  // fetch the next TX byte half a period ahead of its first bit
  assign tx_pop_o = rise_stb_i &&
                    ((state_q == ST_START_S && last) ||
                     (state_q == ST_TX && timer_q[2:0] == 3'd7 && !last));
  // falling points that load or shift the TX register
  assign tx_shift_o = (state_q == ST_START_S && last) || (state_q == ST_TX && !last);

  assign rx_sample_o   = (state_q == ST_RX);
  assign rx_last_bit_o = (state_q == ST_RX) && (timer_q[2:0] == 3'd7);

endmodule

`default_nettype wire

//--- rtl/spi_shifter.sv
/* TX and RX shift registers of the SPI master, MSB first.
   TX changes on the falling points, RX samples on the rising points */
`timescale 1ns/1ns
`default_nettype none

module spi_shifter import spi_pkg::*; (
  input  wire   i_ext_spi_clk_x,
  input  wire   i_srst,
  input  wire   fall_stb_i,
  input  wire   rise_stb_i,
  input  wire   tx_shift_i,
  input  byte_t tx_byte_i,
  input  wire   tx_byte_valid_i,
  input  wire   rx_sample_i,
  input  wire   rx_last_bit_i,
  input  wire   cipo_i,
  output logic  copi_o,
  output byte_t rx_byte_o,
  output logic  rx_wr_o
);

  byte_t      pend_q;
  logic       pend_vld_q;
  byte_t      tx_sreg_q;
  logic [2:0] bit_cnt_q;
  byte_t      rx_sreg_q;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      pend_vld_q <= 1'b0;
      tx_sreg_q  <= '0;
      bit_cnt_q  <= '0;
      rx_wr_o    <= 1'b0;
    end else begin
      if (tx_byte_valid_i)
        pend_vld_q <= 1'b1;
      if (fall_stb_i) begin
        if (tx_shift_i) begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          // byte boundary, empty FIFO sends zeros
          if (bit_cnt_q == 3'd0) begin
            tx_sreg_q  <= pend_vld_q ? pend_q : '0;
            pend_vld_q <= 1'b0;
          end else begin
            tx_sreg_q <= {tx_sreg_q[6:0], 1'b0};
          end
        end else begin
          // line idles low outside TX
          tx_sreg_q <= '0;
          bit_cnt_q <= '0;
        end
      end
      // write strobe the cycle after the eighth sample
      rx_wr_o <= rise_stb_i && rx_sample_i && rx_last_bit_i;
    end
  end

  // byte fetched from the TX FIFO and the input shift register
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (tx_byte_valid_i)
      pend_q <= tx_byte_i;
    if (rise_stb_i && rx_sample_i)
      rx_sreg_q <= {rx_sreg_q[6:0], cipo_i};
  end

  assign copi_o    = tx_sreg_q[7];
  assign rx_byte_o = rx_sreg_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the SPI master testbench with Verilator and run it
# exit status is non-zero when the build or any check fails
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_spi_master -f list.f -o tb_spi_master &&
  ./obj_dir/tb_spi_master ||
  exit 1

//--- testbench/spi_master_assertions.sv
/* concurrent checks on chip select, SCK and the start condition,
   bound into the SPI sequencer */
`timescale 1ns/1ns
`default_nettype none

module spi_master_assertions import spi_pkg::*; (
  input wire        i_ext_spi_clk_x,
  input wire        i_srst,
  input wire        go_i,
  input spi_state_e state_i,
  input wire        csn_i,
  input wire        sck_i,
  input wire        idle_i
);

  // no SCK activity while the slave is deselected
  sck_quiet: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    csn_i |-> !sck_i)
    else $error("sck high while chip select is high");

  // idle means the bus is released
  idle_released: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !(idle_i && !csn_i))
    else $error("idle flag set with chip select low");

  // only a start request moves the FSM out of ST_IDLE
  go_starts: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    (state_i == ST_IDLE) && idle_i && !go_i |=> (state_i == ST_IDLE) && idle_i)
    else $error("state left idle without a start request");

endmodule

bind spi_sequencer spi_master_assertions u_seq_checks (
  .i_ext_spi_clk_x(i_ext_spi_clk_x),
  .i_srst(i_srst),
  .go_i(go_i),
  .state_i(state_q),
  .csn_i(csn_o),
  .sck_i(sck_o),
  .idle_i(idle_o)
);

`default_nettype wire

//--- testbench/tb_spi_master.sv
/* self-checking testbench for the SPI master, random transactions
   against an SPI slave model and a host-side TX FIFO model */
`timescale 1ns/1ns
`default_nettype none

module tb_spi_master import spi_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_RAND = 30;
  // random runs plus the two overflow runs
  localparam int NUM_TXN = NUM_RAND + 2;
  // 15 + 15 bytes, 3 wait periods, lead-in and tail states
  localparam int LONGEST_CLKS = (8 * 30 + 3 + 4 * SS_PERIODS) * SCK_RATIO;
  localparam int TIMEOUT_NS = NUM_TXN * (LONGEST_CLKS + 100) * CLK_PERIOD;

  logic  i_ext_spi_clk_x = 1'b0;
  logic  i_srst;
  byte_t tx_data_i;
  logic  tx_enqueue_i;
  logic  tx_ready_o;
  logic  rx_dequeue_i;
  byte_t rx_data_o;
  logic  rx_valid_o;
  logic  rx_avail_o;
  logic  go_i;
  len_t  tx_len_i;
  len_t  rx_len_i;
  wait_t wait_cyc_i;
  logic  idle_o;
  logic  sck_o;
  logic  csn_o;
  logic  copi_o;
  logic  cipo_i = 1'b0;

  integer seed = 32'h7a69_31e1;
  // host view of the TX FIFO contents
  byte_t tx_model_q [$];
  // bytes the slave saw on copi in the current transaction
  byte_t copi_q [$];
  // slave reply bytes, MSB first on cipo
  byte_t reply_mem [FIFO_DEPTH];
  int    cur_tx;
  int    cur_rx;
  int    cur_wait;
  int    sck_pulses;
  int    csn_low_clks;
  int    txn_count = 0;
  logic  sck_prev = 1'b0;
  logic  csn_prev = 1'b1;
  byte_t copi_acc;

  spi_master_top dut (.*);

  always #(CLK_PERIOD / 2) i_ext_spi_clk_x = ~i_ext_spi_clk_x;

  // run time bound from the longest possible transaction
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: transactions did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s = %0h, expected %0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // SPI slave model, sampled on the falling clock edge
  ////////////////////////////////////////////////////////////

  always @(negedge i_ext_spi_clk_x) begin
    int j;
    if (!i_srst) begin
      // chip select falling opens a transaction
      if (csn_prev && !csn_o) begin
        sck_pulses = 0;
        csn_low_clks = 0;
        copi_q.delete();
      end
      if (!csn_o)
        csn_low_clks++;
      // rising SCK, capture copi during the TX bits
      if (sck_o && !sck_prev && !csn_o) begin
        if (sck_pulses < 8 * cur_tx) begin
          copi_acc = {copi_acc[6:0], copi_o};
          if (sck_pulses % 8 == 7)
            copi_q.push_back(copi_acc);
        end
        sck_pulses++;
      end
      // falling SCK, present the next reply bit ahead of its rising edge
      if (!sck_o && sck_prev) begin
        j = sck_pulses - (8 * cur_tx + cur_wait);
        if (j >= 0 && j < 8 * cur_rx)
          cipo_i = reply_mem[j / 8][7 - j % 8];
        else
          cipo_i = 1'b0;
      end
      if (csn_o && !csn_prev)
        txn_count++;
      sck_prev = sck_o;
      csn_prev = csn_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // one transaction with its checks
  ////////////////////////////////////////////////////////////

  task automatic run_txn(input int tx, input int rx, input int wt, input int n_enq);
    byte_t exp_q [$];
    byte_t b;
    int    target;
    while (!idle_o)
      @(negedge i_ext_spi_clk_x);
    // load the TX FIFO, bytes past its depth are lost
    for (int i = 0; i < n_enq; i++) begin
      check_bit("tx_ready_o", tx_ready_o, tx_model_q.size() < FIFO_DEPTH);
      b = byte_t'($random(seed));
      tx_data_i = b;
      tx_enqueue_i = 1'b1;
      if (tx_model_q.size() < FIFO_DEPTH)
        tx_model_q.push_back(b);
      @(negedge i_ext_spi_clk_x);
    end
    tx_enqueue_i = 1'b0;
    check_bit("tx_ready_o", tx_ready_o, tx_model_q.size() < FIFO_DEPTH);
    // queued bytes first, zeros once the FIFO runs dry
    for (int i = 0; i < tx; i++) begin
      if (tx_model_q.size() > 0)
        exp_q.push_back(tx_model_q.pop_front());
      else
        exp_q.push_back(8'h00);
    end
    for (int i = 0; i < rx; i++)
      reply_mem[i] = byte_t'($random(seed));
    cur_tx = tx;
    cur_rx = rx;
    // no wait phase without a receive phase
    cur_wait = (rx == 0) ? 0 : wt;
    target = txn_count + 1;
    tx_len_i = len_t'(tx);
    rx_len_i = len_t'(rx);
    wait_cyc_i = wait_t'(wt);
    go_i = 1'b1;
    @(negedge i_ext_spi_clk_x);
    go_i = 1'b0;
    check_bit("idle_o", idle_o, 1'b0);
    // start request while busy, lengths in use must stay
    tx_len_i = len_t'($random(seed));
    rx_len_i = len_t'($random(seed));
    wait_cyc_i = wait_t'($random(seed));
    go_i = 1'b1;
    @(negedge i_ext_spi_clk_x);
    go_i = 1'b0;
    while (txn_count != target)
      @(negedge i_ext_spi_clk_x);
    check_count("sck pulses", sck_pulses, 8 * (tx + rx) + cur_wait);
    check_count("csn low clocks", csn_low_clks,
                (8 * (tx + rx) + cur_wait + 2 * SS_PERIODS) * SCK_RATIO);
    check_count("copi byte count", copi_q.size(), tx);
    foreach (exp_q[i])
      check_byte("copi byte", copi_q[i], exp_q[i]);
    // drain RX, valid exactly one cycle after each dequeue
    for (int i = 0; i < rx; i++) begin
      check_bit("rx_avail_o", rx_avail_o, 1'b1);
      rx_dequeue_i = 1'b1;
      @(negedge i_ext_spi_clk_x);
      rx_dequeue_i = 1'b0;
      check_bit("rx_valid_o", rx_valid_o, 1'b1);
      check_byte("rx_data_o", rx_data_o, reply_mem[i]);
      @(negedge i_ext_spi_clk_x);
      check_bit("rx_valid_o", rx_valid_o, 1'b0);
    end
    check_bit("rx_avail_o", rx_avail_o, 1'b0);
  endtask

  initial begin
    int tx;
    int rx;
    int wt;
    i_srst = 1'b1;
    tx_data_i = '0;
    tx_enqueue_i = 1'b0;
    rx_dequeue_i = 1'b0;
    go_i = 1'b0;
    tx_len_i = '0;
    rx_len_i = '0;
    wait_cyc_i = '0;
    repeat (10) @(negedge i_ext_spi_clk_x);
    i_srst = 1'b0;
    // values straight out of reset
    check_bit("csn_o", csn_o, 1'b1);
    check_bit("sck_o", sck_o, 1'b0);
    check_bit("copi_o", copi_o, 1'b0);
    check_bit("idle_o", idle_o, 1'b1);
    check_bit("tx_ready_o", tx_ready_o, 1'b1);
    check_bit("rx_avail_o", rx_avail_o, 1'b0);
    check_bit("rx_valid_o", rx_valid_o, 1'b0);
    // overfill the TX FIFO, the leftover byte goes out in the next run
    run_txn(15, 3, 1, FIFO_DEPTH + 1);
    run_txn(2, 0, 2, 0);
    for (int n = 0; n < NUM_RAND; n++) begin
      tx = 1 + $unsigned($random(seed)) % 15;
      rx = $unsigned($random(seed)) % 16;
      wt = $unsigned($random(seed)) % 4;
      run_txn(tx, rx, wt, $unsigned($random(seed)) % (tx + 1));
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
